// ==== cpu_pkg.sv ====
//////////////////////////////////////////////////
// Shared types and constants for the RV32I core
// Import with cpu_pkg::* in each module header
//////////////////////////////////////////////////

package cpu_pkg;

    // Word and field widths
    typedef logic [31:0] xlen_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0] reg_addr_t;

    localparam addr_t RESET_PC = 32'h0000_0000;
    localparam int NUM_REGS = 32;

    //////////////////////////////////////////////////
    // Major opcodes
    localparam logic [6:0] OPCODE_OP = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_LUI = 7'b0110111;
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;

    //////////////////////////////////////////////////
    // Decoded operations

    // PASS_B forwards the U immediate for LUI
    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        SLTU,
        SLL,
        SRL,
        SRA,
        PASS_B
    } alu_op_t;

    typedef enum logic {
        BEQ,
        BNE
    } branch_op_t;

    // Fetch request, wait for data, hold in buffer
    typedef enum logic [1:0] {
        IDLE,
        WAIT,
        HOLD
    } fetch_state_t;

endpackage

// ==== unit_issue_if.sv ====
//////////////////////////////////////////////////
// Issue port from decode to one execution unit
// Units are always ready, valid pulses once per op
//////////////////////////////////////////////////

`timescale 1ns/1ps

interface unit_issue_if import cpu_pkg::*; ();
    logic valid;
    alu_op_t alu_fn;
    branch_op_t br_fn;
    xlen_t rs1_data;
    xlen_t rs2_data;
    xlen_t imm;
    addr_t pc;
    reg_addr_t rd;

    modport issue (output valid, alu_fn, br_fn, rs1_data, rs2_data, imm, pc, rd);
    modport unit (input valid, alu_fn, br_fn, rs1_data, rs2_data, imm, pc, rd);
endinterface

// ==== fetch.sv ====
//////////////////////////////////////////////////
// Instruction fetch with a one-entry buffer
// Local memory answers one cycle after instr_en
//////////////////////////////////////////////////

`timescale 1ns/1ps

module fetch import cpu_pkg::*; (
    input logic clk,
    input logic reset,
    input logic redirect,
    input addr_t redirect_pc,
    input logic take,
    output logic instr_en,
    output addr_t instr_addr,
    input instr_t instr_data,
    output logic buf_valid,
    output instr_t buf_instr,
    output addr_t buf_pc
);

    fetch_state_t state;
    addr_t pc;
    addr_t pc_seq;

    // pc always holds the address of the word in flight or in the buffer
    assign pc_seq = pc + 32'd4;

    // Next request goes out as soon as decode takes the buffered word
    assign instr_en = !reset && !redirect &&
                      ((state == IDLE) || (state == HOLD && take));
    assign instr_addr = (state == HOLD) ? pc_seq : pc;

    assign buf_valid = (state == HOLD);
    assign buf_pc = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            pc <= RESET_PC;
        end else if (redirect) begin
            // Drop whatever is buffered or outstanding
            state <= IDLE;
            pc <= redirect_pc;
        end else begin
            case (state)
                IDLE: state <= WAIT;
                WAIT: state <= HOLD;
                HOLD: begin
                    if (take) begin
                        pc <= pc_seq;
                        state <= WAIT;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Capture returned word
    always_ff @(posedge clk) begin
        if (state == WAIT)
            buf_instr <= instr_data;
    end

endmodule

// ==== decode_and_issue.sv ====
//////////////////////////////////////////////////
// Decode, scoreboard check and single issue
// Sends each op to the ALU or the branch unit
//////////////////////////////////////////////////

`timescale 1ns/1ps

module decode_and_issue import cpu_pkg::*; (
    input logic clk,
    input logic reset,
    input logic buf_valid,
    input instr_t buf_instr,
    input addr_t buf_pc,
    output logic take,
    input logic redirect,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    input xlen_t rs1_data,
    input xlen_t rs2_data,
    input logic rs1_busy,
    input logic rs2_busy,
    output logic set_pending,
    output reg_addr_t set_rd,
    unit_issue_if.issue alu_issue,
    unit_issue_if.issue br_issue
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t rd;
    xlen_t imm_i;
    xlen_t imm_u;
    xlen_t imm_b;

    logic is_alu;
    logic is_branch;
    logic op_b_imm;
    alu_op_t alu_fn;
    branch_op_t br_fn;
    xlen_t imm;
    logic uses_rs1;
    logic uses_rs2;
    logic hazard;
    logic branch_wait;
    logic issue_alu;
    logic issue_br;

    //////////////////////////////////////////////////
    // Field extraction
    assign opcode = buf_instr[6:0];
    assign funct3 = buf_instr[14:12];
    assign funct7 = buf_instr[31:25];
    assign rd = buf_instr[11:7];
    assign rs1_addr = buf_instr[19:15];
    assign rs2_addr = buf_instr[24:20];

    assign imm_i = {{20{buf_instr[31]}}, buf_instr[31:20]};
    assign imm_u = {buf_instr[31:12], 12'b0};
    assign imm_b = {{19{buf_instr[31]}}, buf_instr[31], buf_instr[7],
                    buf_instr[30:25], buf_instr[11:8], 1'b0};

    // Anything not matched here stays a no-op
    always_comb begin
        is_alu = 1'b0;
        is_branch = 1'b0;
        op_b_imm = 1'b0;
        alu_fn = ADD;
        br_fn = BEQ;
        imm = '0;
        case (opcode)
            OPCODE_LUI: begin
                is_alu = 1'b1;
                alu_fn = PASS_B;
                imm = imm_u;
            end
            OPCODE_OP_IMM: begin
                imm = imm_i;
                op_b_imm = 1'b1;
                is_alu = 1'b1;
                case (funct3)
                    3'b000: alu_fn = ADD;
                    3'b010: alu_fn = SLT;
                    3'b011: alu_fn = SLTU;
                    3'b100: alu_fn = XOR;
                    3'b110: alu_fn = OR;
                    3'b111: alu_fn = AND;
                    3'b001: begin
                        alu_fn = SLL;
                        is_alu = (funct7 == 7'h00);
                    end
                    default: begin
                        alu_fn = funct7[5] ? SRA : SRL;
                        is_alu = (funct7 == 7'h00) || (funct7 == 7'h20);
                    end
                endcase
            end
            OPCODE_OP: begin
                is_alu = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: alu_fn = ADD;
                    {7'h20, 3'b000}: alu_fn = SUB;
                    {7'h00, 3'b001}: alu_fn = SLL;
                    {7'h00, 3'b010}: alu_fn = SLT;
                    {7'h00, 3'b011}: alu_fn = SLTU;
                    {7'h00, 3'b100}: alu_fn = XOR;
                    {7'h00, 3'b101}: alu_fn = SRL;
                    {7'h20, 3'b101}: alu_fn = SRA;
                    {7'h00, 3'b110}: alu_fn = OR;
                    {7'h00, 3'b111}: alu_fn = AND;
                    default: is_alu = 1'b0;
                endcase
            end
            OPCODE_BRANCH: begin
                imm = imm_b;
                is_branch = (funct3 == 3'b000) || (funct3 == 3'b001);
                br_fn = funct3[0] ? BNE : BEQ;
            end
            default: ;
        endcase
    end

    //////////////////////////////////////////////////
    // Scoreboard stall and issue
    assign uses_rs1 = is_branch || (is_alu && opcode != OPCODE_LUI);
    assign uses_rs2 = is_branch || (is_alu && opcode == OPCODE_OP);
    assign hazard = (uses_rs1 && rs1_busy) || (uses_rs2 && rs2_busy);

    // Redirect means the buffered word is on the wrong path
    assign take = buf_valid && !branch_wait && !redirect && !hazard;
    assign issue_alu = take && is_alu;
    assign issue_br = take && is_branch;

    assign set_pending = issue_alu && (rd != '0);
    assign set_rd = rd;

    // Hold off one cycle until the branch outcome is known
    always_ff @(posedge clk) begin
        if (reset)
            branch_wait <= 1'b0;
        else
            branch_wait <= issue_br;
    end

    assign alu_issue.valid = issue_alu;
    assign alu_issue.alu_fn = alu_fn;
    assign alu_issue.br_fn = br_fn;
    assign alu_issue.rs1_data = rs1_data;
    // I-type immediate replaces rs2
    assign alu_issue.rs2_data = op_b_imm ? imm : rs2_data;
    assign alu_issue.imm = imm;
    assign alu_issue.pc = buf_pc;
    assign alu_issue.rd = rd;

    assign br_issue.valid = issue_br;
    assign br_issue.alu_fn = alu_fn;
    assign br_issue.br_fn = br_fn;
    assign br_issue.rs1_data = rs1_data;
    assign br_issue.rs2_data = rs2_data;
    assign br_issue.imm = imm;
    assign br_issue.pc = buf_pc;
    assign br_issue.rd = rd;

endmodule

// ==== register_file.sv ====
//////////////////////////////////////////////////
// Integer registers with a pending-write scoreboard
// Also produces the registered retire report
//////////////////////////////////////////////////

`timescale 1ns/1ps

module register_file import cpu_pkg::*; (
    input logic clk,
    input logic reset,
    input reg_addr_t rs1_addr,
    input reg_addr_t rs2_addr,
    output xlen_t rs1_data,
    output xlen_t rs2_data,
    output logic rs1_busy,
    output logic rs2_busy,
    input logic set_pending,
    input reg_addr_t set_rd,
    input logic wb_valid,
    input reg_addr_t wb_rd,
    input xlen_t wb_data,
    output logic retire_valid,
    output reg_addr_t retire_rd,
    output xlen_t retire_data
);

    xlen_t regs [1:NUM_REGS-1];
    logic [NUM_REGS-1:0] pending;
    logic [NUM_REGS-1:0] set_mask;
    logic [NUM_REGS-1:0] clear_mask;
    logic wb_write;

    // x0 reads zero and is never pending
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];
    assign rs1_busy = pending[rs1_addr];
    assign rs2_busy = pending[rs2_addr];

    assign wb_write = wb_valid && (wb_rd != '0);

    always_comb begin
        set_mask = '0;
        clear_mask = '0;
        if (set_pending)
            set_mask[set_rd] = 1'b1;
        if (wb_valid)
            clear_mask[wb_rd] = 1'b1;
    end

    // A new issue to the same register wins over the clearing writeback
    always_ff @(posedge clk) begin
        if (reset)
            pending <= '0;
        else
            pending <= (pending & ~clear_mask) | set_mask;
    end

    always_ff @(posedge clk) begin
        if (wb_write)
            regs[wb_rd] <= wb_data;
    end

    //////////////////////////////////////////////////
    // Retire report
    always_ff @(posedge clk) begin
        if (reset)
            retire_valid <= 1'b0;
        else
            retire_valid <= wb_write;
    end

    always_ff @(posedge clk) begin
        retire_rd <= wb_rd;
        retire_data <= wb_data;
    end

endmodule

// ==== alu_unit.sv ====
//////////////////////////////////////////////////
// Single-cycle integer ALU
// Result is registered and handed to writeback
//////////////////////////////////////////////////

`timescale 1ns/1ps

module alu_unit import cpu_pkg::*; (
    input logic clk,
    input logic reset,
    unit_issue_if.unit issue,
    output logic wb_valid,
    output reg_addr_t wb_rd,
    output xlen_t wb_data
);

    xlen_t op_a;
    xlen_t op_b;
    xlen_t result;
    logic [4:0] shamt;

    assign op_a = issue.rs1_data;
    // LUI takes the U immediate directly
    assign op_b = (issue.alu_fn == PASS_B) ? issue.imm : issue.rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (issue.alu_fn)
            ADD: result = op_a + op_b;
            SUB: result = op_a - op_b;
            AND: result = op_a & op_b;
            OR: result = op_a | op_b;
            XOR: result = op_a ^ op_b;
            SLT: result = xlen_t'($signed(op_a) < $signed(op_b));
            SLTU: result = xlen_t'(op_a < op_b);
            SLL: result = op_a << shamt;
            SRL: result = op_a >> shamt;
            SRA: result = xlen_t'($signed(op_a) >>> shamt);
            default: result = op_b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            wb_valid <= 1'b0;
        else
            wb_valid <= issue.valid;
    end

    always_ff @(posedge clk) begin
        wb_rd <= issue.rd;
        wb_data <= result;
    end

endmodule

// ==== branch_unit.sv ====
//////////////////////////////////////////////////
// BEQ and BNE resolution
// Taken branches redirect fetch one cycle later
//////////////////////////////////////////////////

`timescale 1ns/1ps

module branch_unit import cpu_pkg::*; (
    input logic clk,
    input logic reset,
    unit_issue_if.unit issue,
    output logic redirect,
    output addr_t redirect_pc
);

    logic equal;
    logic taken;
    addr_t target;

    assign equal = (issue.rs1_data == issue.rs2_data);
    assign taken = (issue.br_fn == BEQ) ? equal : !equal;
    assign target = issue.pc + issue.imm;

    always_ff @(posedge clk) begin
        if (reset)
            redirect <= 1'b0;
        else
            redirect <= issue.valid && taken;
    end

    always_ff @(posedge clk) begin
        redirect_pc <= target;
    end

endmodule

// ==== cpu_core.sv ====
//////////////////////////////////////////////////
// In-order RV32I integer core, top level
// Instruction memory port and retire report only
//////////////////////////////////////////////////

`timescale 1ns/1ps

module cpu_core import cpu_pkg::*; (
    input logic clk,
    input logic reset,
    output logic instr_en,
    output addr_t instr_addr,
    input instr_t instr_data,
    output logic retire_valid,
    output reg_addr_t retire_rd,
    output xlen_t retire_data
);

    //////////////////////////////////////////////////
    // Connecting signals
    logic buf_valid;
    instr_t buf_instr;
    addr_t buf_pc;
    logic take;

    logic redirect;
    addr_t redirect_pc;

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    xlen_t rs1_data;
    xlen_t rs2_data;
    logic rs1_busy;
    logic rs2_busy;
    logic set_pending;
    reg_addr_t set_rd;

    logic wb_valid;
    reg_addr_t wb_rd;
    xlen_t wb_data;

    unit_issue_if alu_issue ();
    unit_issue_if br_issue ();

    //////////////////////////////////////////////////
    // Front end
    fetch fetch_block (
        .clk (clk),
        .reset (reset),
        .redirect (redirect),
        .redirect_pc (redirect_pc),
        .take (take),
        .instr_en (instr_en),
        .instr_addr (instr_addr),
        .instr_data (instr_data),
        .buf_valid (buf_valid),
        .buf_instr (buf_instr),
        .buf_pc (buf_pc)
    );

    decode_and_issue decode_and_issue_block (
        .clk (clk),
        .reset (reset),
        .buf_valid (buf_valid),
        .buf_instr (buf_instr),
        .buf_pc (buf_pc),
        .take (take),
        .redirect (redirect),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rs1_busy (rs1_busy),
        .rs2_busy (rs2_busy),
        .set_pending (set_pending),
        .set_rd (set_rd),
        .alu_issue (alu_issue),
        .br_issue (br_issue)
    );

    register_file register_file_block (
        .clk (clk),
        .reset (reset),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rs1_busy (rs1_busy),
        .rs2_busy (rs2_busy),
        .set_pending (set_pending),
        .set_rd (set_rd),
        .wb_valid (wb_valid),
        .wb_rd (wb_rd),
        .wb_data (wb_data),
        .retire_valid (retire_valid),
        .retire_rd (retire_rd),
        .retire_data (retire_data)
    );

    //////////////////////////////////////////////////
    // Execution units
    alu_unit alu_unit_block (
        .clk (clk),
        .reset (reset),
        .issue (alu_issue),
        .wb_valid (wb_valid),
        .wb_rd (wb_rd),
        .wb_data (wb_data)
    );

    branch_unit branch_unit_block (
        .clk (clk),
        .reset (reset),
        .issue (br_issue),
        .redirect (redirect),
        .redirect_pc (redirect_pc)
    );

endmodule

// ==== tb_ref_model.svh ====
//////////////////////////////////////////////////
// Instruction encoders and an ISA-level model
// Included inside the testbench module body
//////////////////////////////////////////////////

`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// R-type word for the OP opcode
function automatic instr_t reg_op(input logic [6:0] f7, input logic [2:0] f3,
                                  input reg_addr_t rd, input reg_addr_t rs1,
                                  input reg_addr_t rs2);
    return {f7, rs2, rs1, f3, rd, OPCODE_OP};
endfunction

// I-type word for the OP-IMM opcode
function automatic instr_t imm_op(input logic [2:0] f3, input reg_addr_t rd,
                                  input reg_addr_t rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, OPCODE_OP_IMM};
endfunction

function automatic instr_t lui_insn(input reg_addr_t rd, input logic [19:0] imm);
    return {imm, rd, OPCODE_LUI};
endfunction

// Byte offset relative to the branch itself
function automatic instr_t cond_branch(input logic [2:0] f3, input reg_addr_t rs1,
                                       input reg_addr_t rs2, input int off);
    logic [12:0] o;
    o = off[12:0];
    return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], OPCODE_BRANCH};
endfunction

// Result of one OP or OP-IMM word, ok is low for reserved encodings
function automatic xlen_t int_op(input instr_t w, input xlen_t a, input xlen_t b,
                                 output logic ok);
    logic imm_form;
    logic alt;
    imm_form = (w[6:0] == OPCODE_OP_IMM);
    alt = w[30];
    case (w[14:12])
        3'b001: ok = (w[31:25] == 7'h00);
        3'b101: ok = (w[31:25] == 7'h00) || (w[31:25] == 7'h20);
        default: ok = imm_form || (w[31:25] == 7'h00) ||
                      (w[31:25] == 7'h20 && w[14:12] == 3'b000);
    endcase
    case (w[14:12])
        3'b000: return (alt && !imm_form) ? a - b : a + b;
        3'b001: return a << b[4:0];
        3'b010: return {31'b0, $signed(a) < $signed(b)};
        3'b011: return {31'b0, a < b};
        3'b100: return a ^ b;
        3'b101: return alt ? xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'b110: return a | b;
        default: return a & b;
    endcase
endfunction

// Runs prog until the closing self-loop and fills the expected retires
function automatic void run_model();
    xlen_t x [0:31];
    addr_t pc;
    addr_t next_pc;
    instr_t w;
    xlen_t res;
    logic ok;
    int steps;
    x = '{default: '0};
    exp_rd.delete();
    exp_data.delete();
    pc = RESET_PC;
    steps = 0;
    while (steps < 4096) begin
        w = prog[pc[9:2]];
        if (w == cond_branch(3'b000, 5'd0, 5'd0, 0))
            break;
        next_pc = pc + 32'd4;
        ok = 1'b0;
        res = '0;
        case (w[6:0])
            OPCODE_LUI: begin
                res = {w[31:12], 12'b0};
                ok = 1'b1;
            end
            OPCODE_OP: res = int_op(w, x[w[19:15]], x[w[24:20]], ok);
            OPCODE_OP_IMM: res = int_op(w, x[w[19:15]], {{20{w[31]}}, w[31:20]}, ok);
            OPCODE_BRANCH: begin
                // funct3 000 is BEQ, 001 is BNE
                if (w[14:13] == 2'b00 && ((x[w[19:15]] == x[w[24:20]]) != w[12]))
                    next_pc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end
            default: ;
        endcase
        if (ok && w[11:7] != 5'd0) begin
            x[w[11:7]] = res;
            exp_rd.push_back(w[11:7]);
            exp_data.push_back(res);
        end
        pc = next_pc;
        steps++;
    end
endfunction

`endif

// ==== tb_cpu_core.sv ====
//////////////////////////////////////////////////
// Testbench for the RV32I core
// Runs six programs and checks every retire
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_cpu_core import cpu_pkg::*; ();

    localparam int NUM_TESTS = 6;

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic reset_q = 1'b0;
    logic instr_en;
    addr_t instr_addr;
    instr_t instr_data = '0;
    logic retire_valid;
    reg_addr_t retire_rd;
    xlen_t retire_data;

    instr_t prog [0:255];
    int prog_len;
    reg_addr_t exp_rd [$];
    xlen_t exp_data [$];
    int seen;
    int errors = 0;
    int pass_count = 0;
    int fail_count = 0;
    int watch_cycles = 0;
    int seed;
    logic first_fetch_done = 1'b0;

    `include "tb_ref_model.svh"

    cpu_core dut_i (
        .clk (clk),
        .reset (reset),
        .instr_en (instr_en),
        .instr_addr (instr_addr),
        .instr_data (instr_data),
        .retire_valid (retire_valid),
        .retire_rd (retire_rd),
        .retire_data (retire_data)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        reset_q <= reset;
        // One cycle of read latency
        if (instr_en)
            instr_data <= prog[instr_addr[9:2]];
    end

    //////////////////////////////////////////////////
    // Checks
    assert property (@(posedge clk) (reset && reset_q) |-> !retire_valid)
        else begin
            $display("Mismatch at %0t ns: retire_valid high during reset", $time);
            errors++;
        end

    always @(negedge clk) begin
        if (reset) begin
            first_fetch_done = 1'b0;
            seen = 0;
        end else begin
            if (instr_en && !first_fetch_done) begin
                first_fetch_done = 1'b1;
                assert (instr_addr == RESET_PC) else begin
                    $display("Mismatch at %0t ns: first fetch from %h, expected %h",
                             $time, instr_addr, RESET_PC);
                    errors++;
                end
            end
            if (retire_valid) begin
                assert (seen < exp_rd.size()) else begin
                    $display("Unexpected extra retire of x%0d at %0t ns", retire_rd, $time);
                    errors++;
                end
                if (seen < exp_rd.size()) begin
                    assert (retire_rd == exp_rd[seen] && retire_data == exp_data[seen])
                        else begin
                        $display("Mismatch at %0t ns: retire %0d wrote x%0d=%h, expected x%0d=%h",
                                 $time, seen, retire_rd, retire_data, exp_rd[seen],
                                 exp_data[seen]);
                        errors++;
                    end
                    seen++;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Programs
    task automatic emit(input instr_t w);
        prog[prog_len[7:0]] = w;
        prog_len++;
    endtask

    task automatic build_program(input int t);
        logic [31:0] rnd;
        // Unused words decode as unsupported
        for (int i = 0; i < 256; i++)
            prog[i[7:0]] = {i[24:0], 7'h7f};
        prog_len = 0;
        case (t)
            0: begin
                emit(imm_op(3'b000, 5'd1, 5'd0, 12'd5));
                emit(imm_op(3'b000, 5'd2, 5'd1, 12'hffd));
            end
            1: begin
                for (int round = 0; round < 2; round++) begin
                    rnd = $random(seed);
                    emit(lui_insn(5'd1, rnd[31:12]));
                    emit(imm_op(3'b000, 5'd1, 5'd1, rnd[11:0]));
                    rnd = $random(seed);
                    emit(lui_insn(5'd2, rnd[31:12]));
                    emit(imm_op(3'b000, 5'd2, 5'd2, rnd[11:0]));
                    emit(reg_op(7'h00, 3'b000, 5'd10, 5'd1, 5'd2));
                    emit(reg_op(7'h20, 3'b000, 5'd11, 5'd1, 5'd2));
                    emit(reg_op(7'h00, 3'b001, 5'd12, 5'd1, 5'd2));
                    emit(reg_op(7'h00, 3'b010, 5'd13, 5'd1, 5'd2));
                    emit(reg_op(7'h00, 3'b011, 5'd14, 5'd1, 5'd2));
                    emit(reg_op(7'h00, 3'b100, 5'd15, 5'd1, 5'd2));
                    emit(reg_op(7'h00, 3'b101, 5'd16, 5'd1, 5'd2));
                    emit(reg_op(7'h20, 3'b101, 5'd17, 5'd1, 5'd2));
                    emit(reg_op(7'h00, 3'b110, 5'd18, 5'd1, 5'd2));
                    emit(reg_op(7'h00, 3'b111, 5'd19, 5'd1, 5'd2));
                    rnd = $random(seed);
                    emit(imm_op(3'b000, 5'd20, 5'd1, rnd[11:0]));
                    emit(imm_op(3'b010, 5'd21, 5'd2, rnd[23:12]));
                    emit(imm_op(3'b011, 5'd22, 5'd1, rnd[31:20]));
                    emit(imm_op(3'b100, 5'd23, 5'd2, rnd[11:0]));
                    emit(imm_op(3'b110, 5'd24, 5'd1, rnd[23:12]));
                    emit(imm_op(3'b111, 5'd25, 5'd2, rnd[31:20]));
                    emit(imm_op(3'b001, 5'd26, 5'd1, {7'h00, rnd[4:0]}));
                    emit(imm_op(3'b101, 5'd27, 5'd2, {7'h00, rnd[9:5]}));
                    emit(imm_op(3'b101, 5'd28, 5'd2, {7'h20, rnd[14:10]}));
                end
            end
            2: begin
                rnd = $random(seed);
                emit(imm_op(3'b000, 5'd5, 5'd0, rnd[11:0]));
                // Each op reads the register written just before it
                for (int k = 0; k < 8; k++) begin
                    rnd = $random(seed);
                    if (k[0] == 1'b0)
                        emit(imm_op(3'b000, reg_addr_t'(6 + k), reg_addr_t'(5 + k), rnd[11:0]));
                    else
                        emit(reg_op(7'h00, k[1] ? 3'b100 : 3'b000, reg_addr_t'(6 + k),
                                    reg_addr_t'(5 + k), reg_addr_t'(5 + k)));
                end
                for (int k = 0; k < 3; k++)
                    emit(imm_op(3'b000, 5'd13, 5'd13, 12'd1));
            end
            3: begin
                // Loop pass counter starts from zero
                emit(imm_op(3'b000, 5'd14, 5'd0, 12'd0));
                emit(imm_op(3'b000, 5'd1, 5'd0, 12'd3));
                emit(imm_op(3'b000, 5'd2, 5'd0, 12'd3));
                emit(imm_op(3'b000, 5'd3, 5'd0, 12'd7));
                emit(cond_branch(3'b000, 5'd1, 5'd2, 12));
                emit(imm_op(3'b000, 5'd10, 5'd0, 12'd1));
                emit(imm_op(3'b000, 5'd11, 5'd0, 12'd2));
                emit(cond_branch(3'b001, 5'd1, 5'd2, 8));
                emit(imm_op(3'b000, 5'd12, 5'd0, 12'd4));
                emit(cond_branch(3'b000, 5'd1, 5'd3, 8));
                emit(imm_op(3'b000, 5'd13, 5'd0, 12'd5));
                emit(imm_op(3'b000, 5'd4, 5'd0, 12'd2));
                // Loop body runs twice through the backward BNE
                emit(imm_op(3'b000, 5'd4, 5'd4, 12'hfff));
                emit(imm_op(3'b000, 5'd14, 5'd14, 12'd1));
                emit(cond_branch(3'b001, 5'd4, 5'd0, -8));
                emit(cond_branch(3'b001, 5'd1, 5'd3, 8));
                emit(imm_op(3'b000, 5'd15, 5'd0, 12'd9));
            end
            4: begin
                rnd = $random(seed);
                emit(imm_op(3'b000, 5'd0, 5'd0, rnd[11:0]));
                emit(lui_insn(5'd0, rnd[31:12]));
                emit(reg_op(7'h00, 3'b000, 5'd0, 5'd0, 5'd0));
                emit(imm_op(3'b000, 5'd1, 5'd0, rnd[23:12]));
                emit(reg_op(7'h00, 3'b000, 5'd2, 5'd0, 5'd1));
                emit(reg_op(7'h20, 3'b000, 5'd3, 5'd0, 5'd1));
                emit(reg_op(7'h00, 3'b110, 5'd4, 5'd0, 5'd0));
                emit(imm_op(3'b000, 5'd0, 5'd1, 12'd1));
                emit(reg_op(7'h00, 3'b100, 5'd5, 5'd1, 5'd0));
            end
            default: begin
                emit(imm_op(3'b000, 5'd1, 5'd0, 12'd7));
                emit(32'h0000_2083);
                emit(32'h0220_80b3);
                emit(imm_op(3'b001, 5'd1, 5'd1, {7'h20, 5'd3}));
                emit(cond_branch(3'b100, 5'd0, 5'd1, 8));
                emit(32'hffff_ffff);
                emit(reg_op(7'h00, 3'b000, 5'd2, 5'd1, 5'd1));
                emit(imm_op(3'b000, 5'd3, 5'd2, 12'd1));
            end
        endcase
        emit(cond_branch(3'b000, 5'd0, 5'd0, 0));
    endtask

    function automatic string test_name(input int t);
        case (t)
            0: return "reset";
            1: return "alu operations";
            2: return "hazard chains";
            3: return "branches";
            4: return "register x0";
            default: return "unsupported encodings";
        endcase
    endfunction

    task automatic run_test(input int t);
        int errors_before;
        int quiet;
        errors_before = errors;
        @(posedge clk);
        reset <= 1'b1;
        build_program(t);
        run_model();
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        // Done once every retire is seen and the core has gone quiet
        quiet = 0;
        while (seen < exp_rd.size() || quiet < 20) begin
            @(posedge clk);
            if (seen < exp_rd.size() || retire_valid)
                quiet = 0;
            else
                quiet++;
        end
        if (errors == errors_before)
            pass_count++;
        else
            fail_count++;
        $display("Test %0d (%s): %0d of %0d retires checked, %s", t, test_name(t),
                 seen, exp_rd.size(), (errors == errors_before) ? "passed" : "failed");
    endtask

    //////////////////////////////////////////////////
    // Main sequence and watchdog
    initial begin
        int total;
        seed = 51706;
        total = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            build_program(t);
            total += prog_len;
        end
        watch_cycles = total * 200;
        for (int t = 0; t < NUM_TESTS; t++)
            run_test(t);
        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

    initial begin
        wait (watch_cycles > 0);
        repeat (watch_cycles) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", watch_cycles);
        $display("Something failed");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+.
cpu_pkg.sv
unit_issue_if.sv
fetch.sv
decode_and_issue.sv
register_file.sv
alu_unit.sv
branch_unit.sv
cpu_core.sv
tb_cpu_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the core testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    -f compile.f --top-module tb_cpu_core -Mdir obj_dir -o sim_cpu_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_cpu_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Everything OK" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
